// File: dc_diffusion.f
logic/dc_diffusion_pkg.sv
logic/quantize_single.sv
logic/dc_error_corrector.sv
logic/dc_error_store.sv
logic/mb_dc_sequencer.sv
logic/dc_diffusion_top.sv
testbench/dc_diffusion_props.sv
testbench/dc_diffusion_tb.sv

// File: testbench/dc_diffusion_tb.sv
// Directed and random tests of the chroma DC error-diffusion stage
// Compares every result against a reference model of the diffusion and quantizer rules
`timescale 1ns/1ps
`default_nettype none

module dc_diffusion_tb;
    import dc_diffusion_pkg::*;

    localparam int MB_COLS   = 4;
    localparam int MB_ROWS   = 3;
    localparam int Q_SHIFT   = 17;
    localparam int MB_CYCLES = 20;
    localparam int NUM_MB    = 25;
    localparam int TIMEOUT   = NUM_MB * MB_CYCLES + 2 * MB_CYCLES + 100;

    logic          clk;
    logic          rst_n;
    logic          mb_valid_i;
    mb_coefs_t     mb_coefs_i;
    quant_params_t qp_i;
    logic          busy_o;
    logic          out_valid_o;
    mb_coefs_t     levels_o;
    mb_pos_t       mb_x_o;
    mb_pos_t       mb_y_o;

    int            errors = 0;
    int            cycles = 0;
    logic [31:0]   lfsr_state = 32'hd2a65198;
    quant_params_t qp_cur;

    // Reference model state
    int mx = 0;
    int my = 0;
    int top_a_ref  [MB_COLS][2];
    int top_b_ref  [MB_COLS][2];
    int left_a_ref [2];
    int left_b_ref [2];

    dc_diffusion_top #(
        .MB_COLS (MB_COLS),
        .MB_ROWS (MB_ROWS)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mb_valid_i  (mb_valid_i),
        .mb_coefs_i  (mb_coefs_i),
        .qp_i        (qp_i),
        .busy_o      (busy_o),
        .out_valid_o (out_valid_o),
        .levels_o    (levels_o),
        .mb_x_o      (mb_x_o),
        .mb_y_o      (mb_y_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run did not finish within %0d cycles, errors so far %0d", TIMEOUT, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Stimulus helpers
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int take_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    task automatic check(input string name, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // --------------------
    // Reference model
    function automatic coef_t diffuse_ref(coef_t v, int t, int l);
        int adj;
        adj = (7 * t + 8 * l) >>> 3;
        return coef_t'(int'(v) + adj);
    endfunction

    task automatic quantize_ref(input coef_t v, output coef_t lvl, output int err);
        longint mag;
        longint lv;
        longint resid;
        bit     neg;
        neg = (v < 0);
        mag = neg ? -longint'(v) : longint'(v);
        if (mag <= longint'(qp_cur.zthresh))
            lv = 0;
        else
            lv = (mag * longint'(qp_cur.iq) + longint'(qp_cur.bias)) >>> Q_SHIFT;
        resid = mag - lv * longint'(qp_cur.q);
        if (neg)
            resid = -resid;
        resid = resid >>> 1;
        if (resid > 127)
            resid = 127;
        else if (resid < -128)
            resid = -128;
        err = int'(resid);
        lvl = neg ? coef_t'(-lv) : coef_t'(lv);
    endtask

    task automatic model_mb(input mb_coefs_t c, output mb_coefs_t lv);
        int ta;
        int tb;
        int la;
        int lb;
        int e [4];
        for (int p = 0; p < 2; p++) begin
            ta = (my != 0) ? top_a_ref[mx][p] : 0;
            tb = (my != 0) ? top_b_ref[mx][p] : 0;
            la = (mx != 0) ? left_a_ref[p] : 0;
            lb = (mx != 0) ? left_b_ref[p] : 0;
            quantize_ref(diffuse_ref(c.c[p*4], ta, la), lv.c[p*4], e[0]);
            quantize_ref(diffuse_ref(c.c[p*4+1], tb, e[0]), lv.c[p*4+1], e[1]);
            quantize_ref(diffuse_ref(c.c[p*4+2], e[0], lb), lv.c[p*4+2], e[2]);
            quantize_ref(diffuse_ref(c.c[p*4+3], e[1], e[2]), lv.c[p*4+3], e[3]);
            top_a_ref[mx][p] = e[2];
            top_b_ref[mx][p] = e[3];
            left_a_ref[p]    = e[1];
            left_b_ref[p]    = e[3];
        end
        if (mx == MB_COLS - 1) begin
            mx = 0;
            my = (my == MB_ROWS - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
    endtask

    // --------------------
    // DUT access
    task automatic set_params(input quant_params_t qp);
        qp_cur = qp;
        @(posedge clk);
        qp_i <= qp;
    endtask

    task automatic send_mb(input mb_coefs_t c);
        @(posedge clk);
        mb_valid_i <= 1'b1;
        mb_coefs_i <= c;
        @(posedge clk);
        mb_valid_i <= 1'b0;
    endtask

    task automatic wait_result(input string name, output bit got);
        got = 1'b0;
        for (int i = 0; i < MB_CYCLES && !got; i++) begin
            @(negedge clk);
            got = out_valid_o;
        end
        if (!got) begin
            $display("Error in %s: no result within %0d cycles", name, MB_CYCLES);
            errors++;
        end
    endtask

    task automatic compare_result(input string name, input mb_coefs_t exp_lv,
                                  input int ex, input int ey);
        for (int i = 0; i < 8; i++)
            check($sformatf("%s level %0d", name, i), exp_lv.c[i], levels_o.c[i]);
        check({name, " x"}, ex, mb_x_o);
        check({name, " y"}, ey, mb_y_o);
    endtask

    task automatic run_mb(input string name, input mb_coefs_t c);
        mb_coefs_t exp_lv;
        int        ex;
        int        ey;
        bit        got;
        ex = mx;
        ey = my;
        model_mb(c, exp_lv);
        send_mb(c);
        wait_result(name, got);
        if (got)
            compare_result(name, exp_lv, ex, ey);
    endtask

    // --------------------
    // Directed tests
    task automatic test_origin();
        mb_coefs_t c;
        c.c = {16'sd9, -16'sd15, 16'sd0, 16'sd3, -16'sd20, 16'sd20, -16'sd7, 16'sd12};
        run_mb("origin", c);
    endtask

    task automatic test_first_row();
        mb_coefs_t c;
        for (int k = 1; k < MB_COLS; k++) begin
            for (int i = 0; i < 8; i++)
                c.c[i] = coef_t'(((i * 37 + k * 53) % 211) - 105);
            run_mb($sformatf("first_row x%0d", k), c);
        end
    endtask

    task automatic test_later_rows();
        mb_coefs_t c;
        for (int k = 0; k < MB_COLS * (MB_ROWS - 1); k++) begin
            for (int i = 0; i < 8; i++)
                c.c[i] = coef_t'(((i * 71 + k * 29 + 13) % 301) - 150);
            run_mb($sformatf("later_rows mb%0d", k), c);
        end
    endtask

    task automatic test_busy_drop();
        mb_coefs_t c;
        mb_coefs_t c_drop;
        mb_coefs_t exp_lv;
        int        ex;
        int        ey;
        bit        got;
        for (int i = 0; i < 8; i++) begin
            c.c[i]      = coef_t'(i * 19 - 70);
            c_drop.c[i] = coef_t'(300 - i * 41);
        end
        ex = mx;
        ey = my;
        model_mb(c, exp_lv);
        send_mb(c);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("busy_drop busy", 1, busy_o);
        // Second pulse lands mid-macroblock
        send_mb(c_drop);
        wait_result("busy_drop", got);
        if (got)
            compare_result("busy_drop", exp_lv, ex, ey);
        for (int i = 0; i < MB_CYCLES; i++) begin
            @(negedge clk);
            if (out_valid_o) begin
                $display("Error in busy_drop: a pulse sent while busy produced a result");
                errors++;
            end
        end
    endtask

    task automatic test_frame_random();
        mb_coefs_t c;
        int        v;
        for (int k = 0; k < MB_COLS * MB_ROWS; k++) begin
            for (int i = 0; i < 8; i++) begin
                v = take_bits(10);
                if (v >= 512)
                    v = v - 1024;
                c.c[i] = coef_t'(v);
            end
            run_mb($sformatf("frame_random mb%0d", k), c);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        mb_valid_i = 1'b0;
        mb_coefs_i = '0;
        qp_cur     = '{q: 16'd24, iq: 16'd5461, bias: 32'd65536, zthresh: 32'd20};
        qp_i       = qp_cur;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_origin();
        test_first_row();
        test_later_rows();
        test_busy_drop();
        set_params('{q: 16'd40, iq: 16'd3277, bias: 32'd21845, zthresh: 32'd26});
        test_frame_random();

        $display("Tests finished with %0d errors", errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/dc_diffusion_props.sv
// Assertions on the corrector's pulses and start discipline
// Bound into every dc_error_corrector instance
`timescale 1ns/1ps
`default_nettype none

module dc_diffusion_props (
    input wire logic                          clk,
    input wire logic                          rst_n,
    input wire logic                          start_i,
    input wire dc_diffusion_pkg::mb_pos_t     y_i,
    input wire dc_diffusion_pkg::corr_state_e state,
    input wire logic                          top_rd_en_o,
    input wire logic                          done_o
);
    import dc_diffusion_pkg::*;

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else $error("done held longer than one cycle");

    a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        top_rd_en_o |=> !top_rd_en_o)
        else $error("top read enable held longer than one cycle");

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> state == IDLE)
        else $error("start seen outside IDLE");

    // No row above in the first row
    a_rd_row: assert property (@(posedge clk) disable iff (!rst_n)
        top_rd_en_o |-> y_i != '0)
        else $error("top read requested in the first row");

endmodule

bind dc_error_corrector dc_diffusion_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .y_i         (y_i),
    .state       (state),
    .top_rd_en_o (top_rd_en_o),
    .done_o      (done_o)
);

`default_nettype wire

// File: logic/dc_diffusion_top.sv
// Chroma DC error-diffusion stage, one macroblock in flight at a time
// Sets the frame size in macroblocks for the sequencer and the error store
`timescale 1ns/1ps
`default_nettype none

module dc_diffusion_top #(
    parameter int MB_COLS = 4,
    parameter int MB_ROWS = 3
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            mb_valid_i,
    input  wire dc_diffusion_pkg::mb_coefs_t     mb_coefs_i,
    input  wire dc_diffusion_pkg::quant_params_t qp_i,
    output logic                                 busy_o,
    output logic                                 out_valid_o,
    output dc_diffusion_pkg::mb_coefs_t          levels_o,
    output dc_diffusion_pkg::mb_pos_t            mb_x_o,
    output dc_diffusion_pkg::mb_pos_t            mb_y_o
);
    import dc_diffusion_pkg::*;

    logic      start;
    logic      done;
    logic      top_rd_en;
    mb_pos_t   x;
    mb_pos_t   y;
    mb_coefs_t coefs;
    mb_coefs_t levels;
    mb_err_t   mb_err;
    nbr_err_t  top_err;
    nbr_err_t  left_err;

    mb_dc_sequencer #(
        .MB_COLS (MB_COLS),
        .MB_ROWS (MB_ROWS)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .mb_valid_i  (mb_valid_i),
        .mb_coefs_i  (mb_coefs_i),
        .busy_o      (busy_o),
        .start_o     (start),
        .x_o         (x),
        .y_o         (y),
        .coefs_o     (coefs),
        .done_i      (done),
        .levels_i    (levels),
        .out_valid_o (out_valid_o),
        .levels_o    (levels_o),
        .pos_x_o     (mb_x_o),
        .pos_y_o     (mb_y_o)
    );

    dc_error_corrector u_corr (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .x_i         (x),
        .y_i         (y),
        .coefs_i     (coefs),
        .qp_i        (qp_i),
        .top_err_i   (top_err),
        .left_err_i  (left_err),
        .top_rd_en_o (top_rd_en),
        .levels_o    (levels),
        .mb_err_o    (mb_err),
        .done_o      (done)
    );

    // Errors are written back when the corrector finishes
    dc_error_store #(
        .MB_COLS (MB_COLS)
    ) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en_i    (top_rd_en),
        .x_i        (x),
        .wr_en_i    (done),
        .mb_err_i   (mb_err),
        .top_err_o  (top_err),
        .left_err_o (left_err)
    );

endmodule

`default_nettype wire

// File: logic/mb_dc_sequencer.sv
// Accepts one macroblock at a time, walks the frame position and starts the corrector
// Results leave with out_valid_o one cycle after the corrector's done
`timescale 1ns/1ps
`default_nettype none

module mb_dc_sequencer #(
    parameter int MB_COLS = 4,
    parameter int MB_ROWS = 3
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        mb_valid_i,
    input  wire dc_diffusion_pkg::mb_coefs_t mb_coefs_i,
    output logic                             busy_o,
    output logic                             start_o,
    output dc_diffusion_pkg::mb_pos_t        x_o,
    output dc_diffusion_pkg::mb_pos_t        y_o,
    output dc_diffusion_pkg::mb_coefs_t      coefs_o,
    input  wire logic                        done_i,
    input  wire dc_diffusion_pkg::mb_coefs_t levels_i,
    output logic                             out_valid_o,
    output dc_diffusion_pkg::mb_coefs_t      levels_o,
    output dc_diffusion_pkg::mb_pos_t        pos_x_o,
    output dc_diffusion_pkg::mb_pos_t        pos_y_o
);
    import dc_diffusion_pkg::*;

    logic accept;
    logic last_col;
    logic last_row;

    // Pulses during busy are dropped
    assign accept   = mb_valid_i && !busy_o;
    assign last_col = (x_o == mb_pos_t'(MB_COLS - 1));
    assign last_row = (y_o == mb_pos_t'(MB_ROWS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o      <= 1'b0;
            start_o     <= 1'b0;
            out_valid_o <= 1'b0;
            x_o         <= '0;
            y_o         <= '0;
            pos_x_o     <= '0;
            pos_y_o     <= '0;
        end else begin
            start_o     <= accept;
            out_valid_o <= done_i;
            if (accept)
                busy_o <= 1'b1;
            else if (out_valid_o)
                busy_o <= 1'b0;
            if (done_i) begin
                pos_x_o <= x_o;
                pos_y_o <= y_o;
                // Raster advance with frame wrap
                if (last_col) begin
                    x_o <= '0;
                    y_o <= last_row ? '0 : y_o + 1'b1;
                end else begin
                    x_o <= x_o + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            coefs_o <= mb_coefs_i;
        if (done_i)
            levels_o <= levels_i;
    end

endmodule

`default_nettype wire

// File: logic/dc_error_store.sv
// Keeps the bottom-row errors of the row above, one entry per MB column,
// and the right-column errors of the previous macroblock
`timescale 1ns/1ps
`default_nettype none

module dc_error_store #(
    parameter int MB_COLS = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       rd_en_i,
    input  wire dc_diffusion_pkg::mb_pos_t  x_i,
    input  wire logic                       wr_en_i,
    input  wire dc_diffusion_pkg::mb_err_t  mb_err_i,
    output dc_diffusion_pkg::nbr_err_t      top_err_o,
    output dc_diffusion_pkg::nbr_err_t      left_err_o
);
    import dc_diffusion_pkg::*;

    localparam int AW = (MB_COLS > 1) ? $clog2(MB_COLS) : 1;

    nbr_err_t        top_mem [MB_COLS];
    logic [AW-1:0]   addr;

    assign addr = x_i[AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MB_COLS; i++) begin
                top_mem[i] <= '0;
            end
            top_err_o  <= '0;
            left_err_o <= '0;
        end else begin
            // Read data held until the next request
            if (rd_en_i)
                top_err_o <= top_mem[addr];
            if (wr_en_i) begin
                top_mem[addr] <= '{u_a: mb_err_i.u2, u_b: mb_err_i.u3,
                                   v_a: mb_err_i.v2, v_b: mb_err_i.v3};
                left_err_o    <= '{u_a: mb_err_i.u1, u_b: mb_err_i.u3,
                                   v_a: mb_err_i.v1, v_b: mb_err_i.v3};
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dc_error_corrector.sv
// Diffuses neighbour errors into the eight chroma DC values of one macroblock
// Pulse start_i in IDLE; levels and block errors are valid while done_o is high
`timescale 1ns/1ps
`default_nettype none

module dc_error_corrector (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            start_i,
    input  wire dc_diffusion_pkg::mb_pos_t       x_i,
    input  wire dc_diffusion_pkg::mb_pos_t       y_i,
    input  wire dc_diffusion_pkg::mb_coefs_t     coefs_i,
    input  wire dc_diffusion_pkg::quant_params_t qp_i,
    input  wire dc_diffusion_pkg::nbr_err_t      top_err_i,
    input  wire dc_diffusion_pkg::nbr_err_t      left_err_i,
    output logic                                 top_rd_en_o,
    output dc_diffusion_pkg::mb_coefs_t          levels_o,
    output dc_diffusion_pkg::mb_err_t            mb_err_o,
    output logic                                 done_o
);
    import dc_diffusion_pkg::*;

    corr_state_e state;
    corr_state_e state_nxt;

    nbr_err_t nbr_top;
    nbr_err_t nbr_left;
    nbr_err_t top_q;
    nbr_err_t left_q;
    derr_t    top_a  [2];
    derr_t    left_a [2];
    derr_t    top_b  [2];
    derr_t    left_b [2];

    // Index 0 is the U plane and 1 the V plane
    coef_t q_in  [2];
    coef_t q_lvl [2];
    derr_t q_err [2];
    coef_t lvl_q [2][3];
    derr_t err_q [2][3];

    // Value plus (7*top + 8*left) >>> 3
    function automatic coef_t diffuse(coef_t v, derr_t t, derr_t l);
        logic signed [11:0] acc;
        acc = 12'(t) * 12'sd7 + 12'(l) * 12'sd8;
        return v + coef_t'(acc >>> 3);
    endfunction

    // --------------------
    // State machine
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start_i) begin
                    if (y_i != '0)
                        state_nxt = EN;
                    else
                        state_nxt = (x_i != '0) ? LEFT : NONE;
                end
            end
            EN:    state_nxt = WAIT;
            WAIT:  state_nxt = (x_i != '0) ? BOTH : TOP;
            BOTH, TOP, LEFT, NONE: state_nxt = STEP1;
            STEP9: state_nxt = IDLE;
            default: state_nxt = corr_state_e'(state + 4'd1);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            top_rd_en_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            state       <= state_nxt;
            top_rd_en_o <= (state == EN);
            done_o      <= (state == STEP9);
        end
    end

    // --------------------
    // Missing neighbours read as zero
    assign nbr_top  = (state == BOTH || state == TOP)  ? top_err_i  : '0;
    assign nbr_left = (state == BOTH || state == LEFT) ? left_err_i : '0;

    always_comb begin
        top_a[0]  = nbr_top.u_a;
        top_a[1]  = nbr_top.v_a;
        left_a[0] = nbr_left.u_a;
        left_a[1] = nbr_left.v_a;
        top_b[0]  = top_q.u_b;
        top_b[1]  = top_q.v_b;
        left_b[0] = left_q.u_b;
        left_b[1] = left_q.v_b;
    end

    // --------------------
    // Blocks issue in order 0, 1, 2, 3
    always_ff @(posedge clk) begin
        if (state == BOTH || state == TOP || state == LEFT || state == NONE) begin
            top_q  <= nbr_top;
            left_q <= nbr_left;
        end
        for (int p = 0; p < 2; p++) begin
            case (state)
                BOTH, TOP, LEFT, NONE: begin
                    q_in[p] <= diffuse(coefs_i.c[p*4], top_a[p], left_a[p]);
                end
                STEP3: begin
                    lvl_q[p][0] <= q_lvl[p];
                    err_q[p][0] <= q_err[p];
                    q_in[p]     <= diffuse(coefs_i.c[p*4+1], top_b[p], q_err[p]);
                end
                STEP4: begin
                    q_in[p] <= diffuse(coefs_i.c[p*4+2], err_q[p][0], left_b[p]);
                end
                STEP6: begin
                    lvl_q[p][1] <= q_lvl[p];
                    err_q[p][1] <= q_err[p];
                end
                STEP7: begin
                    lvl_q[p][2] <= q_lvl[p];
                    err_q[p][2] <= q_err[p];
                    // Block 3 takes its left error from block 2 on the quantizer output
                    q_in[p]     <= diffuse(coefs_i.c[p*4+3], err_q[p][1], q_err[p]);
                end
                default: ;
            endcase
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_plane
        quantize_single u_quant (
            .clk     (clk),
            .rst_n   (rst_n),
            .value_i (q_in[p]),
            .qp_i    (qp_i),
            .level_o (q_lvl[p]),
            .err_o   (q_err[p])
        );
    end

    // Block 3 comes straight from the quantizers with inputs held since STEP7
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            levels_o.c[p*4]   = lvl_q[p][0];
            levels_o.c[p*4+1] = lvl_q[p][1];
            levels_o.c[p*4+2] = lvl_q[p][2];
            levels_o.c[p*4+3] = q_lvl[p];
        end
    end

    assign mb_err_o.u1 = err_q[0][1];
    assign mb_err_o.u2 = err_q[0][2];
    assign mb_err_o.u3 = q_err[0];
    assign mb_err_o.v1 = err_q[1][1];
    assign mb_err_o.v2 = err_q[1][2];
    assign mb_err_o.v3 = q_err[1];

endmodule

`default_nettype wire

// File: logic/quantize_single.sv
// Two-stage dead-zone quantizer for one DC value
// Accepts a new value every cycle and returns level and halved error two cycles later
`timescale 1ns/1ps
`default_nettype none

module quantize_single (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire dc_diffusion_pkg::coef_t         value_i,
    input  wire dc_diffusion_pkg::quant_params_t qp_i,
    output dc_diffusion_pkg::coef_t              level_o,
    output dc_diffusion_pkg::derr_t              err_o
);
    import dc_diffusion_pkg::*;

    logic               sign_q;
    logic               dead_q;
    logic [15:0]        mag_q;
    logic [15:0]        mag_d;
    logic [32:0]        scaled;
    logic [15:0]        lvl_mag;
    logic [33:0]        prod;
    logic signed [33:0] resid;
    logic signed [33:0] resid_s;
    logic signed [33:0] half;
    derr_t              err_d;

    // Stage one
    assign mag_d = value_i[COEF_W-1] ? 16'(-value_i) : 16'(value_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_q <= 1'b0;
            dead_q <= 1'b1;
            mag_q  <= '0;
        end else begin
            sign_q <= value_i[COEF_W-1];
            dead_q <= 32'(mag_d) <= qp_i.zthresh;
            mag_q  <= mag_d;
        end
    end

    // Stage two
    assign scaled  = 33'(mag_q) * 33'(qp_i.iq) + 33'(qp_i.bias);
    assign lvl_mag = dead_q ? '0 : 16'(scaled >> QFIX);
    assign prod    = 34'(lvl_mag) * 34'(qp_i.q);
    assign resid   = $signed({18'd0, mag_q}) - $signed(prod);
    assign resid_s = sign_q ? -resid : resid;
    assign half    = resid_s >>> 1;
    assign err_d   = (half > 127) ? 8'sd127 : (half < -128) ? -8'sd128 : derr_t'(half);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_o <= '0;
            err_o   <= '0;
        end else begin
            level_o <= sign_q ? -coef_t'(lvl_mag) : coef_t'(lvl_mag);
            err_o   <= err_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/dc_diffusion_pkg.sv
// Shared widths, types and FSM encoding for the chroma DC error-diffusion stage
// Imported by every RTL block and by the testbench
`default_nettype none

package dc_diffusion_pkg;

    localparam int COEF_W = 16;
    localparam int DERR_W = 8;
    localparam int POS_W  = 10;
    // Fixed-point shift of the quantizer multiply
    localparam int QFIX   = 17;

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [DERR_W-1:0] derr_t;
    typedef logic        [POS_W-1:0]  mb_pos_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
    } quant_params_t;

    // U blocks 0..3 in c[0..3], V blocks 0..3 in c[4..7]
    typedef struct packed {
        coef_t [7:0] c;
    } mb_coefs_t;

    // Top carries blocks 2/3 of the MB above and left carries blocks 1/3 of the left MB
    typedef struct packed {
        derr_t u_a;
        derr_t u_b;
        derr_t v_a;
        derr_t v_b;
    } nbr_err_t;

    typedef struct packed {
        derr_t u1;
        derr_t u2;
        derr_t u3;
        derr_t v1;
        derr_t v2;
        derr_t v3;
    } mb_err_t;

    typedef enum logic [3:0] {
        IDLE, EN, WAIT, BOTH, TOP, LEFT, NONE,
        STEP1, STEP2, STEP3, STEP4, STEP5, STEP6, STEP7, STEP8, STEP9
    } corr_state_e;

endpackage

`default_nettype wire
